// ==== tb.f ====
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/video_ctrl.sv
verilog/pattern_gen.sv
verilog/color_out.sv
verilog/vga_top.sv
verification/tb_vga.sv

// ==== Makefile ====
# Verilator simulation of the VGA subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_vga
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test FAILED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "simulation exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_vga.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_vga import vga_pkg::*; ();

    localparam int H_VIS_AREA_PXL    = 16;
    localparam int H_FRONT_PORCH_PXL = 2;
    localparam int H_SYNC_PULSE_PXL  = 4;
    localparam int H_BACK_PORCH_PXL  = 3;
    localparam int V_VIS_AREA_PXL    = 8;
    localparam int V_FRONT_PORCH_PXL = 1;
    localparam int V_SYNC_PULSE_PXL  = 2;
    localparam int V_BACK_PORCH_PXL  = 2;
    localparam int CHANNEL_BITS      = 2;
    localparam int BAR_SHIFT         = 1;
    localparam int CHECK_SHIFT       = 1;

    localparam int H_TOTAL = H_VIS_AREA_PXL + H_FRONT_PORCH_PXL
                           + H_SYNC_PULSE_PXL + H_BACK_PORCH_PXL;
    localparam int V_TOTAL = V_VIS_AREA_PXL + V_FRONT_PORCH_PXL
                           + V_SYNC_PULSE_PXL + V_BACK_PORCH_PXL;
    localparam int H_NUM_BITS   = $clog2(H_TOTAL);
    localparam int V_NUM_BITS   = $clog2(V_TOTAL);
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int PAD_BITS     = VGA_CHANNEL_BITS - CHANNEL_BITS;
    localparam int CH_MAX       = (1 << CHANNEL_BITS) - 1;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    // upper bound of the frames used by the six tests below
    localparam int TEST_FRAMES     = 22;
    localparam int WATCHDOG_CYCLES = (TEST_FRAMES + 2) * FRAME_CYCLES + RESET_CYCLES;

    typedef struct packed {
        logic [VGA_CHANNEL_BITS-1:0] red;
        logic [VGA_CHANNEL_BITS-1:0] green;
        logic [VGA_CHANNEL_BITS-1:0] blue;
        logic                        h_sync;
        logic                        v_sync;
        logic [H_NUM_BITS-1:0]       h_count;
        logic [V_NUM_BITS-1:0]       v_count;
    } pixel_out_t;

    logic                        clk;
    logic                        rst_n;
    logic                        enable;
    pattern_mode_e               mode;
    logic                        mode_valid;
    logic [3*CHANNEL_BITS-1:0]   solid_color;
    logic [VGA_CHANNEL_BITS-1:0] red;
    logic [VGA_CHANNEL_BITS-1:0] green;
    logic [VGA_CHANNEL_BITS-1:0] blue;
    logic                        h_sync;
    logic                        v_sync;
    logic [H_NUM_BITS-1:0]       h_pxl_count;
    logic [V_NUM_BITS-1:0]       v_pxl_count;

    // model of the pixel currently inside the DUT
    int            m_h;
    int            m_v;
    ctrl_state_e   m_state;
    pattern_mode_e m_pending;
    pattern_mode_e m_active;
    pixel_out_t    exp_out;
    logic          exp_valid;
    logic [31:0]   rng;
    string         test_name;

    vga_top #(
        .H_VIS_AREA_PXL(H_VIS_AREA_PXL), .H_FRONT_PORCH_PXL(H_FRONT_PORCH_PXL),
        .H_SYNC_PULSE_PXL(H_SYNC_PULSE_PXL), .H_BACK_PORCH_PXL(H_BACK_PORCH_PXL),
        .V_VIS_AREA_PXL(V_VIS_AREA_PXL), .V_FRONT_PORCH_PXL(V_FRONT_PORCH_PXL),
        .V_SYNC_PULSE_PXL(V_SYNC_PULSE_PXL), .V_BACK_PORCH_PXL(V_BACK_PORCH_PXL),
        .CHANNEL_BITS(CHANNEL_BITS), .BAR_SHIFT(BAR_SHIFT), .CHECK_SHIFT(CHECK_SHIFT)
    ) DUT (
        .clk(clk), .rst_n(rst_n),
        .enable(enable), .mode(mode), .mode_valid(mode_valid),
        .solid_color(solid_color),
        .red(red), .green(green), .blue(blue),
        .h_sync(h_sync), .v_sync(v_sync),
        .h_pxl_count(h_pxl_count), .v_pxl_count(v_pxl_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic pixel_out_t expected_pixel(input int h, input int v, input logic run_on,
                                                  input pattern_mode_e pmode,
                                                  input logic [3*CHANNEL_BITS-1:0] solid);
        pixel_out_t p;
        int         r;
        int         g;
        int         b;
        int         bar;
        logic       show;
        show = (h < H_VIS_AREA_PXL) && (v < V_VIS_AREA_PXL) && run_on;
        bar  = (h >> BAR_SHIFT) % 8;
        case (pmode)
            PAT_SOLID: begin
                r = int'(solid >> (2 * CHANNEL_BITS)) & CH_MAX;
                g = int'(solid >> CHANNEL_BITS) & CH_MAX;
                b = int'(solid) & CH_MAX;
            end
            PAT_BARS: begin
                r = (bar >= 4) ? CH_MAX : 0;
                g = ((bar / 2) % 2 == 1) ? CH_MAX : 0;
                b = (bar % 2 == 1) ? CH_MAX : 0;
            end
            PAT_CHECKER: begin
                r = (((h >> CHECK_SHIFT) % 2) != ((v >> CHECK_SHIFT) % 2)) ? CH_MAX : 0;
                g = r;
                b = r;
            end
            default: begin
                r = h % (CH_MAX + 1);
                g = v % (CH_MAX + 1);
                b = 0;
            end
        endcase
        p.red     = show ? VGA_CHANNEL_BITS'(r << PAD_BITS) : '0;
        p.green   = show ? VGA_CHANNEL_BITS'(g << PAD_BITS) : '0;
        p.blue    = show ? VGA_CHANNEL_BITS'(b << PAD_BITS) : '0;
        // syncs go low in the window that starts after the front porch
        p.h_sync  = !((h >= H_VIS_AREA_PXL + H_FRONT_PORCH_PXL)
                   && (h < H_VIS_AREA_PXL + H_FRONT_PORCH_PXL + H_SYNC_PULSE_PXL));
        p.v_sync  = !((v >= V_VIS_AREA_PXL + V_FRONT_PORCH_PXL)
                   && (v < V_VIS_AREA_PXL + V_FRONT_PORCH_PXL + V_SYNC_PULSE_PXL));
        p.h_count = H_NUM_BITS'(h);
        p.v_count = V_NUM_BITS'(v);
        return p;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_color(input string name,
                               input logic [VGA_CHANNEL_BITS-1:0] exp_r,
                               input logic [VGA_CHANNEL_BITS-1:0] exp_g,
                               input logic [VGA_CHANNEL_BITS-1:0] exp_b,
                               input logic [VGA_CHANNEL_BITS-1:0] act_r,
                               input logic [VGA_CHANNEL_BITS-1:0] act_g,
                               input logic [VGA_CHANNEL_BITS-1:0] act_b);
        if ({act_r, act_g, act_b} !== {exp_r, exp_g, exp_b}) begin
            stop_with_failure($sformatf("Error %s: color rgb expected %h %h %h actual %h %h %h",
                                        name, exp_r, exp_g, exp_b, act_r, act_g, act_b));
        end
    endtask

    task automatic check_sync(input string name, input logic exp_hs, input logic exp_vs,
                              input logic act_hs, input logic act_vs);
        if ({act_hs, act_vs} !== {exp_hs, exp_vs}) begin
            stop_with_failure($sformatf("Error %s: sync h/v expected %b %b actual %b %b",
                                        name, exp_hs, exp_vs, act_hs, act_vs));
        end
    endtask

    task automatic check_count(input string name,
                               input logic [H_NUM_BITS-1:0] exp_h,
                               input logic [V_NUM_BITS-1:0] exp_v,
                               input logic [H_NUM_BITS-1:0] act_h,
                               input logic [V_NUM_BITS-1:0] act_v);
        if ({act_h, act_v} !== {exp_h, exp_v}) begin
            stop_with_failure($sformatf("Error %s: count h/v expected %0d %0d actual %0d %0d",
                                        name, exp_h, exp_v, act_h, act_v));
        end
    endtask

    // advance one pixel, inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
        mode_valid = 1'b0;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) step();
    endtask

    task automatic goto_pixel(input int h, input int v);
        while (!(m_h == h && m_v == v)) begin
            step();
        end
    endtask

    task automatic goto_frame_start();
        goto_pixel(0, 0);
    endtask

    task automatic strobe_mode(input pattern_mode_e m);
        mode       = m;
        mode_valid = 1'b1;
        step();
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // mirrors the counters and video_ctrl, registering the expected output per edge
    always @(posedge clk) begin : model
        logic          last_pixel;
        pattern_mode_e next_pending;
        if (!rst_n) begin
            exp_out        = '0;
            exp_out.h_sync = 1'b1;
            exp_out.v_sync = 1'b1;
            m_h            = 0;
            m_v            = 0;
            m_state        = ST_OFF;
            m_pending      = PAT_SOLID;
            m_active       = PAT_SOLID;
        end else begin
            exp_out      = expected_pixel(m_h, m_v, m_state == ST_RUN, m_active, solid_color);
            last_pixel   = (m_h == H_TOTAL - 1) && (m_v == V_TOTAL - 1);
            next_pending = mode_valid ? mode : m_pending;
            if (last_pixel) begin
                m_active = next_pending;
            end
            m_pending = next_pending;
            if (!enable) begin
                m_state = ST_OFF;
            end else if (m_state == ST_OFF) begin
                m_state = ST_WAIT_FRAME;
            end else if (m_state == ST_WAIT_FRAME && last_pixel) begin
                m_state = ST_RUN;
            end
            if (m_h == H_TOTAL - 1) begin
                m_h = 0;
                m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
            end else begin
                m_h = m_h + 1;
            end
        end
        exp_valid = 1'b1;
    end

    // outputs are sampled mid-cycle where they are stable
    always @(negedge clk) begin
        if (exp_valid) begin
            check_color(test_name, exp_out.red, exp_out.green, exp_out.blue, red, green, blue);
            check_sync(test_name, exp_out.h_sync, exp_out.v_sync, h_sync, v_sync);
            check_count(test_name, exp_out.h_count, exp_out.v_count, h_pxl_count, v_pxl_count);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure($sformatf("watchdog expired after %0d cycles, the tests did not finish",
                                    WATCHDOG_CYCLES));
    end

    initial begin
        rst_n       = 1'b0;
        enable      = 1'b0;
        mode        = PAT_SOLID;
        mode_valid  = 1'b0;
        solid_color = '0;
        exp_valid   = 1'b0;
        rng         = 32'he81f_20a3;
        test_name   = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // a nonzero solid color must stay hidden while the display is off
        test_name   = "sync_count";
        rng         = xorshift32(rng);
        solid_color = rng[3*CHANNEL_BITS-1:0];
        run_cycles(3 * FRAME_CYCLES);

        test_name = "enable_start";
        goto_pixel(5, 3);
        enable = 1'b1;
        goto_frame_start();
        run_cycles(2 * FRAME_CYCLES);

        test_name = "solid_random";
        repeat (2 * FRAME_CYCLES) begin
            rng         = xorshift32(rng);
            solid_color = rng[3*CHANNEL_BITS-1:0];
            step();
        end

        // several strobes in one frame, the last one decides the next frame
        test_name = "mode_strobe";
        goto_pixel(0, 1);
        for (int i = 0; i < 3; i++) begin
            rng = xorshift32(rng);
            run_cycles(1 + int'(rng % 24));
            rng = xorshift32(rng);
            strobe_mode((i == 2) ? PAT_CHECKER : pattern_mode_e'(rng[1:0]));
        end
        goto_frame_start();
        run_cycles(FRAME_CYCLES);

        for (int i = 1; i < 4; i++) begin
            pattern_mode_e pat;
            pat       = pattern_mode_e'(i);
            test_name = $sformatf("pattern_%s", pat.name());
            strobe_mode(pat);
            goto_frame_start();
            run_cycles(FRAME_CYCLES);
        end

        test_name = "enable_drop";
        rng = xorshift32(rng);
        goto_pixel(int'(rng % H_VIS_AREA_PXL), int'((rng >> 8) % V_VIS_AREA_PXL));
        enable = 1'b0;
        rng    = xorshift32(rng);
        run_cycles(1 + int'(rng % 4));
        enable = 1'b1;
        goto_frame_start();
        run_cycles(2 * FRAME_CYCLES);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/vga_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module vga_top import vga_pkg::*; #(
    parameter int H_VIS_AREA_PXL    = 800,
    parameter int H_FRONT_PORCH_PXL = 40,
    parameter int H_SYNC_PULSE_PXL  = 128,
    parameter int H_BACK_PORCH_PXL  = 88,

    parameter int V_VIS_AREA_PXL    = 600,
    parameter int V_FRONT_PORCH_PXL = 1,
    parameter int V_SYNC_PULSE_PXL  = 4,
    parameter int V_BACK_PORCH_PXL  = 23,

    parameter int CHANNEL_BITS      = 2,
    parameter int BAR_SHIFT         = 7,
    parameter int CHECK_SHIFT       = 5,

    localparam int H_NUM_BITS = $clog2(H_VIS_AREA_PXL + H_FRONT_PORCH_PXL
                                       + H_SYNC_PULSE_PXL + H_BACK_PORCH_PXL),
    localparam int V_NUM_BITS = $clog2(V_VIS_AREA_PXL + V_FRONT_PORCH_PXL
                                       + V_SYNC_PULSE_PXL + V_BACK_PORCH_PXL)
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        enable,
    input  pattern_mode_e               mode,
    input  logic                        mode_valid,
    input  logic [3*CHANNEL_BITS-1:0]   solid_color,

    output logic [VGA_CHANNEL_BITS-1:0] red,
    output logic [VGA_CHANNEL_BITS-1:0] green,
    output logic [VGA_CHANNEL_BITS-1:0] blue,
    output logic                        h_sync,
    output logic                        v_sync,
    output logic [H_NUM_BITS-1:0]       h_pxl_count,
    output logic [V_NUM_BITS-1:0]       v_pxl_count
);

    logic [H_NUM_BITS-1:0]     h_count;
    logic [V_NUM_BITS-1:0]     v_count;
    logic                      h_sync_raw;
    logic                      v_sync_raw;
    logic                      visible;
    logic                      frame_end;
    logic                      run;
    pattern_mode_e             active_mode;
    logic [3*CHANNEL_BITS-1:0] pixel_color;

    vga_timing #(
        .H_VIS_AREA_PXL(H_VIS_AREA_PXL), .H_FRONT_PORCH_PXL(H_FRONT_PORCH_PXL),
        .H_SYNC_PULSE_PXL(H_SYNC_PULSE_PXL), .H_BACK_PORCH_PXL(H_BACK_PORCH_PXL),
        .H_NUM_BITS(H_NUM_BITS),
        .V_VIS_AREA_PXL(V_VIS_AREA_PXL), .V_FRONT_PORCH_PXL(V_FRONT_PORCH_PXL),
        .V_SYNC_PULSE_PXL(V_SYNC_PULSE_PXL), .V_BACK_PORCH_PXL(V_BACK_PORCH_PXL),
        .V_NUM_BITS(V_NUM_BITS)
    ) u_timing (
        .clk(clk), .rst_n(rst_n),
        .h_count(h_count), .v_count(v_count),
        .h_sync(h_sync_raw), .v_sync(v_sync_raw),
        .visible(visible), .frame_end(frame_end)
    );

    video_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .enable(enable), .mode(mode), .mode_valid(mode_valid),
        .frame_end(frame_end),
        .run(run), .active_mode(active_mode)
    );

    pattern_gen #(
        .CHANNEL_BITS(CHANNEL_BITS), .H_NUM_BITS(H_NUM_BITS), .V_NUM_BITS(V_NUM_BITS),
        .BAR_SHIFT(BAR_SHIFT), .CHECK_SHIFT(CHECK_SHIFT)
    ) u_pattern (
        .h_count(h_count), .v_count(v_count),
        .active_mode(active_mode), .solid_color(solid_color),
        .pixel_color(pixel_color)
    );

    color_out #(
        .CHANNEL_BITS(CHANNEL_BITS), .H_NUM_BITS(H_NUM_BITS), .V_NUM_BITS(V_NUM_BITS)
    ) u_out (
        .clk(clk), .rst_n(rst_n),
        .pixel_color(pixel_color), .visible(visible), .run(run),
        .h_sync_in(h_sync_raw), .v_sync_in(v_sync_raw),
        .h_count_in(h_count), .v_count_in(v_count),
        .red(red), .green(green), .blue(blue),
        .h_sync(h_sync), .v_sync(v_sync),
        .h_pxl_count(h_pxl_count), .v_pxl_count(v_pxl_count)
    );

endmodule

`default_nettype wire

// ==== verilog/color_out.sv ====
`default_nettype none
`timescale 1ns/1ps

module color_out import vga_pkg::*; #(
    parameter int CHANNEL_BITS = 2,
    parameter int H_NUM_BITS   = 11,
    parameter int V_NUM_BITS   = 10
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic [3*CHANNEL_BITS-1:0]   pixel_color,
    input  logic                        visible,
    input  logic                        run,
    input  logic                        h_sync_in,
    input  logic                        v_sync_in,
    input  logic [H_NUM_BITS-1:0]       h_count_in,
    input  logic [V_NUM_BITS-1:0]       v_count_in,

    output logic [VGA_CHANNEL_BITS-1:0] red,
    output logic [VGA_CHANNEL_BITS-1:0] green,
    output logic [VGA_CHANNEL_BITS-1:0] blue,
    output logic                        h_sync,
    output logic                        v_sync,
    output logic [H_NUM_BITS-1:0]       h_pxl_count,
    output logic [V_NUM_BITS-1:0]       v_pxl_count
);

    localparam int PAD_BITS = VGA_CHANNEL_BITS - CHANNEL_BITS;

    logic                        show;
    logic                        visible_q;
    logic [VGA_CHANNEL_BITS-1:0] red_w;
    logic [VGA_CHANNEL_BITS-1:0] green_w;
    logic [VGA_CHANNEL_BITS-1:0] blue_w;

    assign show = visible && run;

    // channel bits land in the msbs and the low bits are padded with zeros
    assign red_w   = VGA_CHANNEL_BITS'(pixel_color[3*CHANNEL_BITS-1:2*CHANNEL_BITS]) << PAD_BITS;
    assign green_w = VGA_CHANNEL_BITS'(pixel_color[2*CHANNEL_BITS-1:CHANNEL_BITS]) << PAD_BITS;
    assign blue_w  = VGA_CHANNEL_BITS'(pixel_color[CHANNEL_BITS-1:0]) << PAD_BITS;

    // one register stage keeps colors, syncs and counters on the same pixel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red         <= '0;
            green       <= '0;
            blue        <= '0;
            h_sync      <= 1'b1;
            v_sync      <= 1'b1;
            h_pxl_count <= '0;
            v_pxl_count <= '0;
            visible_q   <= 1'b0;
        end else begin
            red         <= show ? red_w : '0;
            green       <= show ? green_w : '0;
            blue        <= show ? blue_w : '0;
            h_sync      <= h_sync_in;
            v_sync      <= v_sync_in;
            h_pxl_count <= h_count_in;
            v_pxl_count <= v_count_in;
            visible_q   <= visible;
        end
    end

    a_blank_outside: assert property (
        @(posedge clk) disable iff (!rst_n)
        !visible_q |-> ({red, green, blue} == '0)
    ) else $error("color driven outside the visible area");

endmodule

`default_nettype wire

// ==== verilog/pattern_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module pattern_gen import vga_pkg::*; #(
    parameter int CHANNEL_BITS = 2,
    parameter int H_NUM_BITS   = 11,
    parameter int V_NUM_BITS   = 10,
    parameter int BAR_SHIFT    = 7,
    parameter int CHECK_SHIFT  = 5
) (
    input  logic [H_NUM_BITS-1:0]     h_count,
    input  logic [V_NUM_BITS-1:0]     v_count,
    input  pattern_mode_e             active_mode,
    input  logic [3*CHANNEL_BITS-1:0] solid_color,

    output logic [3*CHANNEL_BITS-1:0] pixel_color
);

    logic [2:0]              bar_idx;
    logic                    check_bit;
    logic [CHANNEL_BITS-1:0] bar_red;
    logic [CHANNEL_BITS-1:0] bar_green;
    logic [CHANNEL_BITS-1:0] bar_blue;
    logic [CHANNEL_BITS-1:0] grad_red;
    logic [CHANNEL_BITS-1:0] grad_green;

    // eight vertical bars cycling through the primary and secondary colors
    assign bar_idx   = h_count[BAR_SHIFT+2:BAR_SHIFT];
    assign bar_red   = {CHANNEL_BITS{bar_idx[2]}};
    assign bar_green = {CHANNEL_BITS{bar_idx[1]}};
    assign bar_blue  = {CHANNEL_BITS{bar_idx[0]}};

    // squares alternate wherever the two coordinate bits disagree
    assign check_bit = h_count[CHECK_SHIFT] ^ v_count[CHECK_SHIFT];

    assign grad_red   = h_count[CHANNEL_BITS-1:0];
    assign grad_green = v_count[CHANNEL_BITS-1:0];

    always_comb begin
        case (active_mode)
            PAT_SOLID: begin
                pixel_color = solid_color;
            end
            PAT_BARS: begin
                pixel_color = {bar_red, bar_green, bar_blue};
            end
            PAT_CHECKER: begin
                pixel_color = {(3*CHANNEL_BITS){check_bit}};
            end
            PAT_GRADIENT: begin
                pixel_color = {grad_red, grad_green, {CHANNEL_BITS{1'b0}}};
            end
            default: begin
                pixel_color = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/video_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module video_ctrl import vga_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,

    input  logic          enable,
    input  pattern_mode_e mode,
    input  logic          mode_valid,
    input  logic          frame_end,

    output logic          run,
    output pattern_mode_e active_mode
);

    ctrl_state_e   state;
    ctrl_state_e   state_next;
    pattern_mode_e pending_mode;
    pattern_mode_e pending_next;

    // a strobe in the last pixel of a frame still counts for that frame
    assign pending_next = mode_valid ? mode : pending_mode;

    always_comb begin
        state_next = state;
        if (!enable) begin
            state_next = ST_OFF;
        end else begin
            case (state)
                ST_OFF: begin
                    state_next = ST_WAIT_FRAME;
                end
                ST_WAIT_FRAME: begin
                    if (frame_end) begin
                        state_next = ST_RUN;
                    end
                end
                ST_RUN: begin
                    state_next = ST_RUN;
                end
                default: begin
                    state_next = ST_OFF;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_OFF;
        end else begin
            state <= state_next;
        end
    end

    // the pending mode is promoted only across a frame boundary
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_mode <= PAT_SOLID;
            active_mode  <= PAT_SOLID;
        end else begin
            pending_mode <= pending_next;
            if (frame_end) begin
                active_mode <= pending_next;
            end
        end
    end

    assign run = (state == ST_RUN);

    a_mode_frame_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(active_mode) |-> ($past(frame_end) || !$past(rst_n))
    ) else $error("active_mode changed in mid-frame");

endmodule

`default_nettype wire

// ==== verilog/vga_timing.sv ====
`default_nettype none
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_VIS_AREA_PXL    = 800,
    parameter int H_FRONT_PORCH_PXL = 40,
    parameter int H_SYNC_PULSE_PXL  = 128,
    parameter int H_BACK_PORCH_PXL  = 88,
    parameter int H_NUM_BITS        = 11,

    parameter int V_VIS_AREA_PXL    = 600,
    parameter int V_FRONT_PORCH_PXL = 1,
    parameter int V_SYNC_PULSE_PXL  = 4,
    parameter int V_BACK_PORCH_PXL  = 23,
    parameter int V_NUM_BITS        = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,

    output logic [H_NUM_BITS-1:0] h_count,
    output logic [V_NUM_BITS-1:0] v_count,

    output logic                  h_sync,
    output logic                  v_sync,
    output logic                  visible,
    output logic                  frame_end
);

    localparam int H_TOTAL = H_VIS_AREA_PXL + H_FRONT_PORCH_PXL
                           + H_SYNC_PULSE_PXL + H_BACK_PORCH_PXL;
    localparam int V_TOTAL = V_VIS_AREA_PXL + V_FRONT_PORCH_PXL
                           + V_SYNC_PULSE_PXL + V_BACK_PORCH_PXL;

    // sync pulse window, measured from the start of the line or frame
    localparam int H_SYNC_START = H_VIS_AREA_PXL + H_FRONT_PORCH_PXL;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC_PULSE_PXL;
    localparam int V_SYNC_START = V_VIS_AREA_PXL + V_FRONT_PORCH_PXL;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC_PULSE_PXL;

    logic h_end;
    logic v_end;
    logic h_visible;
    logic v_visible;

    assign h_end = h_count >= H_NUM_BITS'(H_TOTAL - 1);
    assign v_end = v_count >= V_NUM_BITS'(V_TOTAL - 1);

    // horizontal counter runs every cycle and wraps on the last pixel
    always_ff @(posedge clk) begin
        if (!rst_n || h_end) begin
            h_count <= '0;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // the line counter advances on the last pixel of each line
    always_ff @(posedge clk) begin
        if (!rst_n || (h_end && v_end)) begin
            v_count <= '0;
        end else if (h_end) begin
            v_count <= v_count + 1'b1;
        end
    end

    assign h_visible = h_count < H_NUM_BITS'(H_VIS_AREA_PXL);
    assign v_visible = v_count < V_NUM_BITS'(V_VIS_AREA_PXL);
    assign visible   = h_visible && v_visible;

    // both syncs are active low
    assign h_sync = !((h_count >= H_NUM_BITS'(H_SYNC_START))
                   && (h_count < H_NUM_BITS'(H_SYNC_END)));
    assign v_sync = !((v_count >= V_NUM_BITS'(V_SYNC_START))
                   && (v_count < V_NUM_BITS'(V_SYNC_END)));

    assign frame_end = h_end && v_end;

    a_count_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (h_count < H_NUM_BITS'(H_TOTAL)) && (v_count < V_NUM_BITS'(V_TOTAL))
    ) else $error("vga_timing counter out of range h=%0d v=%0d", h_count, v_count);

endmodule

`default_nettype wire

// ==== verilog/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

    // width of each VGA pin group driven off chip
    localparam int VGA_CHANNEL_BITS = 4;

    // pattern selection, applied by video_ctrl only at a frame boundary
    typedef enum logic [1:0] {
        PAT_SOLID    = 2'd0,
        PAT_BARS     = 2'd1,
        PAT_CHECKER  = 2'd2,
        PAT_GRADIENT = 2'd3
    } pattern_mode_e;

    // display sequencing states
    typedef enum logic [1:0] {
        ST_OFF        = 2'd0,
        ST_WAIT_FRAME = 2'd1,
        ST_RUN        = 2'd2
    } ctrl_state_e;

endpackage

`default_nettype wire
